// ==== rtl/audio_config.svh ====
`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

// Capture geometry
`define AUDIO_CHANNELS 8
`define AUDIO_FRAMES 256
`define SAMPLE_BITS 16

// I2S frame of 64 bit positions, left half then right half
`define I2S_FRAME_BITS 64
`define I2S_DIVIDER 15

// ck cycles from bit enable to the receive sample point
`define I2S_SAMPLE_DELAY 5

// First frame position of each sample slot
`define LEFT_FIRST_BIT 1
`define RIGHT_FIRST_BIT 33

// Bus address byte, bits 31 to 24
`define ADDR_REGS 8'h62
`define ADDR_AUDIO 8'h64

`endif

// ==== rtl/audio_pkg.sv ====
`include "audio_config.svh"

package audio_pkg;

    // One microphone or playback sample
    typedef logic [`SAMPLE_BITS-1:0] sample_t;

    typedef logic [$clog2(`AUDIO_CHANNELS)-1:0] chan_t;
    typedef logic [$clog2(`AUDIO_FRAMES)-1:0] frame_t;

    // Channel in the upper bits, frame in the lower bits
    typedef logic [$clog2(`AUDIO_CHANNELS * `AUDIO_FRAMES)-1:0] audio_addr_t;

    // Position within the I2S frame
    typedef logic [$clog2(`I2S_FRAME_BITS)-1:0] bit_posn_t;

    typedef logic [31:0] bus_word_t;

endpackage

// ==== rtl/i2s_clock.sv ====
`timescale 1ns/100ps
`include "audio_config.svh"

module i2s_clock (
    input  logic                  ck,
    input  logic                  rst_n,
    output logic                  bit_en,
    output logic                  sample_en,
    output logic                  frame_start,
    output logic                  sck,
    output logic                  ws,
    output audio_pkg::bit_posn_t  bit_posn
);

    localparam int DIV_W = $clog2(`I2S_DIVIDER);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`I2S_DIVIDER - 1);
    // sck rises once this count is reached
    localparam logic [DIV_W-1:0] SCK_RISE = DIV_W'(`I2S_DIVIDER / 2);
    localparam audio_pkg::bit_posn_t POSN_LAST = audio_pkg::bit_posn_t'(`I2S_FRAME_BITS - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [`I2S_SAMPLE_DELAY-1:0] en_pipe;

    assign bit_en = (div_cnt == DIV_LAST);
    assign frame_start = bit_en && (bit_posn == POSN_LAST);
    assign sample_en = en_pipe[`I2S_SAMPLE_DELAY-1];
    // Right half of the frame has the top position bit set
    assign ws = bit_posn[$bits(audio_pkg::bit_posn_t)-1];

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            sck <= 1'b0;
            bit_posn <= '0;
            en_pipe <= '0;
        end else begin
            en_pipe <= {en_pipe[`I2S_SAMPLE_DELAY-2:0], bit_en};
            if (bit_en) begin
                div_cnt <= '0;
                sck <= 1'b0;
                bit_posn <= bit_posn + 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                if (div_cnt == SCK_RISE - 1'b1) begin
                    sck <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/i2s_rx.sv ====
`timescale 1ns/100ps
`include "audio_config.svh"

module i2s_rx (
    input  logic                  ck,
    input  logic                  rst_n,
    input  logic                  sample_en,
    input  logic                  sd,
    input  audio_pkg::bit_posn_t  bit_posn,
    output audio_pkg::sample_t    left,
    output audio_pkg::sample_t    right
);

    // Last bit position of each slot
    localparam audio_pkg::bit_posn_t LEFT_LAST =
        audio_pkg::bit_posn_t'(`LEFT_FIRST_BIT + `SAMPLE_BITS - 1);
    localparam audio_pkg::bit_posn_t RIGHT_LAST =
        audio_pkg::bit_posn_t'(`RIGHT_FIRST_BIT + `SAMPLE_BITS - 1);

    audio_pkg::sample_t shift;
    audio_pkg::sample_t word;

    // Completed word including the bit being sampled now
    assign word = {shift[`SAMPLE_BITS-2:0], sd};

    always_ff @(posedge ck) begin
        if (sample_en) begin
            shift <= word;
        end
    end

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            left <= '0;
            right <= '0;
        end else if (sample_en) begin
            if (bit_posn == LEFT_LAST) begin
                left <= word;
            end
            if (bit_posn == RIGHT_LAST) begin
                right <= word;
            end
        end
    end

endmodule

// ==== rtl/i2s_tx.sv ====
`timescale 1ns/100ps
`include "audio_config.svh"

module i2s_tx (
    input  logic                  ck,
    input  logic                  rst_n,
    input  logic                  bit_en,
    input  logic                  frame_start,
    input  audio_pkg::bit_posn_t  bit_posn,
    input  audio_pkg::sample_t    tx_left,
    input  audio_pkg::sample_t    tx_right,
    output logic                  sd
);

    localparam audio_pkg::bit_posn_t LEFT_FIRST = audio_pkg::bit_posn_t'(`LEFT_FIRST_BIT);
    localparam audio_pkg::bit_posn_t LEFT_LAST =
        audio_pkg::bit_posn_t'(`LEFT_FIRST_BIT + `SAMPLE_BITS - 1);
    localparam audio_pkg::bit_posn_t RIGHT_FIRST = audio_pkg::bit_posn_t'(`RIGHT_FIRST_BIT);
    localparam audio_pkg::bit_posn_t RIGHT_LAST =
        audio_pkg::bit_posn_t'(`RIGHT_FIRST_BIT + `SAMPLE_BITS - 1);

    audio_pkg::bit_posn_t next_posn;
    audio_pkg::sample_t left_q;
    audio_pkg::sample_t right_q;

    // Position that becomes current at this bit enable
    assign next_posn = bit_posn + 1'b1;

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            left_q <= '0;
            right_q <= '0;
            sd <= 1'b0;
        end else if (frame_start) begin
            // Frame copy, position 0 is idle
            left_q <= tx_left;
            right_q <= tx_right;
            sd <= 1'b0;
        end else if (bit_en) begin
            if (next_posn >= LEFT_FIRST && next_posn <= LEFT_LAST) begin
                sd <= left_q[`SAMPLE_BITS-1];
                left_q <= {left_q[`SAMPLE_BITS-2:0], 1'b0};
            end else if (next_posn >= RIGHT_FIRST && next_posn <= RIGHT_LAST) begin
                sd <= right_q[`SAMPLE_BITS-1];
                right_q <= {right_q[`SAMPLE_BITS-2:0], 1'b0};
            end else begin
                sd <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/frame_capture.sv ====
`timescale 1ns/100ps
`include "audio_config.svh"

module frame_capture (
    input  logic                    ck,
    input  logic                    rst_n,
    input  logic                    frame_start,
    input  audio_pkg::sample_t      mic [`AUDIO_CHANNELS],
    output logic                    we,
    output audio_pkg::audio_addr_t  waddr,
    output audio_pkg::sample_t      wdata,
    output audio_pkg::frame_t       frame
);

    localparam audio_pkg::chan_t LAST_CHAN = audio_pkg::chan_t'(`AUDIO_CHANNELS - 1);

    logic writing;
    audio_pkg::chan_t chan;

    // Frame counter runs downwards, one step per frame
    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            frame <= '0;
        end else if (frame_start) begin
            frame <= frame - 1'b1;
        end
    end

    // Write burst of all channels right after frame start
    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            writing <= 1'b0;
            chan <= '0;
        end else if (frame_start) begin
            writing <= 1'b1;
            chan <= '0;
        end else if (writing) begin
            if (chan == LAST_CHAN) begin
                writing <= 1'b0;
            end else begin
                chan <= chan + 1'b1;
            end
        end
    end

    assign we = writing;
    assign waddr = {chan, frame};

    // Receivers still hold the previous frame here
    assign wdata = mic[chan];

endmodule

// ==== rtl/audio_ram.sv ====
`timescale 1ns/100ps

module audio_ram #(
    parameter int DEPTH = 2048,
    parameter int WIDTH = 16
) (
    input  logic                      ck,
    input  logic                      we,
    input  logic [$clog2(DEPTH)-1:0]  waddr,
    input  logic [$clog2(DEPTH)-1:0]  raddr,
    input  logic [WIDTH-1:0]          wdata,
    output logic [WIDTH-1:0]          rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Capture side
    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Host side, one cycle latency
    always_ff @(posedge ck) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== rtl/host_regs.sv ====
`timescale 1ns/100ps
`include "audio_config.svh"

module host_regs (
    input  logic                    ck,
    input  logic                    rst_n,
    input  logic                    bus_cyc,
    input  logic                    bus_we,
    input  audio_pkg::bus_word_t    bus_adr,
    input  audio_pkg::bus_word_t    bus_wdat,
    output logic                    ack,
    output audio_pkg::bus_word_t    rdt,
    input  audio_pkg::frame_t       frame,
    output audio_pkg::audio_addr_t  ram_raddr,
    input  audio_pkg::sample_t      ram_rdata,
    output audio_pkg::sample_t      tx_left,
    output audio_pkg::sample_t      tx_right
);

    localparam int BUS_W = $bits(audio_pkg::bus_word_t);
    localparam int SAMPLE_W = $bits(audio_pkg::sample_t);
    localparam int FRAME_W = $bits(audio_pkg::frame_t);
    localparam int RAM_AW = $bits(audio_pkg::audio_addr_t);

    // Register indices
    localparam logic [1:0] REG_FRAME = 2'd0;
    localparam logic [1:0] REG_LEFT = 2'd1;
    localparam logic [1:0] REG_RIGHT = 2'd2;

    logic sel_regs;
    logic sel_audio;
    logic hit;
    logic acked;
    logic [1:0] reg_idx;
    audio_pkg::bus_word_t reg_rdata;

    assign sel_regs = (bus_adr[31:24] == `ADDR_REGS);
    assign sel_audio = (bus_adr[31:24] == `ADDR_AUDIO);
    assign hit = bus_cyc && (sel_regs || sel_audio);
    assign reg_idx = bus_adr[3:2];

    // Word address straight into the RAM read port
    assign ram_raddr = bus_adr[RAM_AW+1:2];

    // Single ack per access, re-armed once bus_cyc drops
    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
            acked <= 1'b0;
        end else begin
            ack <= hit && !ack && !acked;
            if (!bus_cyc) begin
                acked <= 1'b0;
            end else if (ack) begin
                acked <= 1'b1;
            end
        end
    end

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            tx_left <= '0;
            tx_right <= '0;
        end else if (ack && bus_we && sel_regs) begin
            if (reg_idx == REG_LEFT) begin
                tx_left <= bus_wdat[SAMPLE_W-1:0];
            end
            if (reg_idx == REG_RIGHT) begin
                tx_right <= bus_wdat[SAMPLE_W-1:0];
            end
        end
    end

    always_comb begin
        case (reg_idx)
            REG_FRAME: reg_rdata = {{(BUS_W-FRAME_W){1'b0}}, frame};
            REG_LEFT:  reg_rdata = {{(BUS_W-SAMPLE_W){1'b0}}, tx_left};
            REG_RIGHT: reg_rdata = {{(BUS_W-SAMPLE_W){1'b0}}, tx_right};
            default:   reg_rdata = '0;
        endcase
    end

    // Read data only during the ack cycle
    always_comb begin
        rdt = '0;
        if (ack && !bus_we) begin
            if (sel_regs) begin
                rdt = reg_rdata;
            end else if (sel_audio) begin
                rdt = {{(BUS_W-SAMPLE_W){1'b0}}, ram_rdata};
            end
        end
    end

endmodule

// ==== rtl/audio_capture_top.sv ====
`timescale 1ns/100ps
`include "audio_config.svh"

module audio_capture_top (
    input  logic                            ck,
    input  logic                            rst_n,
    input  logic                            bus_cyc,
    input  logic                            bus_we,
    input  audio_pkg::bus_word_t            bus_adr,
    input  audio_pkg::bus_word_t            bus_wdat,
    output logic                            ack,
    output audio_pkg::bus_word_t            rdt,
    input  logic [`AUDIO_CHANNELS/2-1:0]    sd_in,
    output logic                            sck,
    output logic                            ws,
    output logic                            sd_out
);

    logic bit_en;
    logic sample_en;
    logic frame_start;
    audio_pkg::bit_posn_t bit_posn;

    audio_pkg::sample_t mic [`AUDIO_CHANNELS];
    audio_pkg::sample_t tx_left;
    audio_pkg::sample_t tx_right;

    logic cap_we;
    audio_pkg::audio_addr_t cap_waddr;
    audio_pkg::sample_t cap_wdata;
    audio_pkg::frame_t frame;

    audio_pkg::audio_addr_t ram_raddr;
    audio_pkg::sample_t ram_rdata;

    i2s_clock i_clock (
        .ck          (ck),
        .rst_n       (rst_n),
        .bit_en      (bit_en),
        .sample_en   (sample_en),
        .frame_start (frame_start),
        .sck         (sck),
        .ws          (ws),
        .bit_posn    (bit_posn)
    );

    // Each line carries a stereo pair of microphones
    for (genvar n = 0; n < `AUDIO_CHANNELS / 2; n++) begin : g_rx
        i2s_rx i_rx (
            .ck        (ck),
            .rst_n     (rst_n),
            .sample_en (sample_en),
            .sd        (sd_in[n]),
            .bit_posn  (bit_posn),
            .left      (mic[2*n]),
            .right     (mic[2*n+1])
        );
    end

    i2s_tx i_tx (
        .ck          (ck),
        .rst_n       (rst_n),
        .bit_en      (bit_en),
        .frame_start (frame_start),
        .bit_posn    (bit_posn),
        .tx_left     (tx_left),
        .tx_right    (tx_right),
        .sd          (sd_out)
    );

    frame_capture i_capture (
        .ck          (ck),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .mic         (mic),
        .we          (cap_we),
        .waddr       (cap_waddr),
        .wdata       (cap_wdata),
        .frame       (frame)
    );

    audio_ram #(
        .DEPTH (`AUDIO_CHANNELS * `AUDIO_FRAMES),
        .WIDTH (`SAMPLE_BITS)
    ) i_ram (
        .ck    (ck),
        .we    (cap_we),
        .waddr (cap_waddr),
        .raddr (ram_raddr),
        .wdata (cap_wdata),
        .rdata (ram_rdata)
    );

    host_regs i_regs (
        .ck        (ck),
        .rst_n     (rst_n),
        .bus_cyc   (bus_cyc),
        .bus_we    (bus_we),
        .bus_adr   (bus_adr),
        .bus_wdat  (bus_wdat),
        .ack       (ack),
        .rdt       (rdt),
        .frame     (frame),
        .ram_raddr (ram_raddr),
        .ram_rdata (ram_rdata),
        .tx_left   (tx_left),
        .tx_right  (tx_right)
    );

endmodule

// ==== test/tb_audio_capture.sv ====
`timescale 1ns/100ps
`include "audio_config.svh"

module tb_audio_capture;

    localparam int ROWS = 6;
    localparam int LINES = `AUDIO_CHANNELS / 2;
    localparam int FRAME_CYCLES = `I2S_FRAME_BITS * `I2S_DIVIDER;
    // One frame per row, plus the reset frame and one spare
    localparam int CYCLE_LIMIT = (ROWS + 2) * FRAME_CYCLES;

    logic ck = 1'b0;
    logic rst_n;
    logic bus_cyc;
    logic bus_we;
    audio_pkg::bus_word_t bus_adr;
    audio_pkg::bus_word_t bus_wdat;
    logic ack;
    audio_pkg::bus_word_t rdt;
    logic [LINES-1:0] sd_in;
    logic sck;
    logic ws;
    logic sd_out;

    // Stimulus table, one row per frame
    audio_pkg::sample_t rx_left [ROWS][LINES];
    audio_pkg::sample_t rx_right [ROWS][LINES];
    audio_pkg::sample_t tx_left [ROWS];
    audio_pkg::sample_t tx_right [ROWS];

    integer seed = 32'hd342_79aa;
    int checks = 0;
    int errors = 0;
    int cycles = 0;

    // I2S frame and position as seen from the pins
    int frame_idx = 0;
    int posn = 0;
    logic prev_sck = 1'b0;
    logic prev_ws = 1'b0;
    logic [`I2S_FRAME_BITS-1:0] sd_bits = '0;

    always #4 ck = ~ck;

    audio_capture_top i_dut (
        .ck       (ck),
        .rst_n    (rst_n),
        .bus_cyc  (bus_cyc),
        .bus_we   (bus_we),
        .bus_adr  (bus_adr),
        .bus_wdat (bus_wdat),
        .ack      (ack),
        .rdt      (rdt),
        .sd_in    (sd_in),
        .sck      (sck),
        .ws       (ws),
        .sd_out   (sd_out)
    );

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end else begin
            $display("Pass %s", name);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("Error: %s", what);
    endtask

    function automatic audio_pkg::bus_word_t reg_addr(input int idx);
        return {`ADDR_REGS, 24'(idx * 4)};
    endfunction

    // Channel sits above the frame in the word address
    function automatic audio_pkg::bus_word_t audio_addr(input int chan, input int frame);
        return {`ADDR_AUDIO, 24'((chan * `AUDIO_FRAMES + frame) * 4)};
    endfunction

    // Expected sd_out of one frame, bit index is the position
    function automatic logic [`I2S_FRAME_BITS-1:0] tx_frame_bits(input int f);
        logic [`I2S_FRAME_BITS-1:0] bits;
        audio_pkg::sample_t l;
        audio_pkg::sample_t r;
        bits = '0;
        if (f > 0 && f <= ROWS) begin
            l = tx_left[f-1];
            r = tx_right[f-1];
            for (int p = 0; p < `SAMPLE_BITS; p++) begin
                bits[`LEFT_FIRST_BIT + p] = l[`SAMPLE_BITS - 1 - p];
                bits[`RIGHT_FIRST_BIT + p] = r[`SAMPLE_BITS - 1 - p];
            end
        end
        return bits;
    endfunction

    // Serial bit of one line at one position, MSB first in each slot
    function automatic logic source_bit(input int row, input int line, input int p);
        if (row >= ROWS) begin
            return 1'b1;
        end
        if (p >= `LEFT_FIRST_BIT && p < `LEFT_FIRST_BIT + `SAMPLE_BITS) begin
            return rx_left[row][line][`SAMPLE_BITS - 1 - (p - `LEFT_FIRST_BIT)];
        end
        if (p >= `RIGHT_FIRST_BIT && p < `RIGHT_FIRST_BIT + `SAMPLE_BITS) begin
            return rx_right[row][line][`SAMPLE_BITS - 1 - (p - `RIGHT_FIRST_BIT)];
        end
        // Idle positions carry junk the receivers must ignore
        return 1'b1;
    endfunction

    // Position tracking, sd_out capture and rdt idle check
    always @(negedge ck) begin
        if (rst_n) begin
            if (prev_ws && !ws) begin
                check_value($sformatf("sd_out frame %0d", frame_idx),
                            tx_frame_bits(frame_idx), sd_bits);
                frame_idx++;
                posn = 0;
                sd_bits = '0;
            end else if (prev_sck && !sck) begin
                posn++;
                // Word select high for the right half of the frame
                if (ws !== (posn >= `I2S_FRAME_BITS / 2)) begin
                    report_error($sformatf("ws is wrong at position %0d", posn));
                end
            end
            if (!prev_sck && sck) begin
                sd_bits[posn] = sd_out;
            end
            if (!ack && rdt !== '0) begin
                report_error("rdt is not zero while ack is low");
            end
        end
        prev_sck = sck;
        prev_ws = ws;
    end

    // I2S source, four lines
    always @(posedge ck) begin
        for (int n = 0; n < LINES; n++) begin
            sd_in[n] <= source_bit(frame_idx, n, posn);
        end
    end

    always @(posedge ck) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic bus_access(input logic we, input audio_pkg::bus_word_t adr,
                              input audio_pkg::bus_word_t wdat,
                              output audio_pkg::bus_word_t data);
        int waited;
        waited = 0;
        @(posedge ck);
        bus_cyc <= 1'b1;
        bus_we <= we;
        bus_adr <= adr;
        bus_wdat <= wdat;
        @(negedge ck);
        while (!ack && waited < 16) begin
            @(negedge ck);
            waited++;
        end
        if (!ack) begin
            report_error($sformatf("no ack for address %h", adr));
        end
        data = rdt;
        // Cycle held past the ack, which must not repeat
        repeat (2) begin
            @(negedge ck);
            if (ack) begin
                report_error($sformatf("second ack for address %h", adr));
            end
        end
        @(posedge ck);
        bus_cyc <= 1'b0;
        bus_we <= 1'b0;
    endtask

    task automatic bus_read(input audio_pkg::bus_word_t adr, output audio_pkg::bus_word_t data);
        bus_access(1'b0, adr, '0, data);
    endtask

    task automatic bus_write(input audio_pkg::bus_word_t adr, input audio_pkg::bus_word_t wdat);
        audio_pkg::bus_word_t unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wait_frames(input int target);
        while (frame_idx < target) begin
            @(posedge ck);
        end
    endtask

    initial begin
        audio_pkg::bus_word_t data;
        audio_pkg::sample_t sample;
        audio_pkg::frame_t frame;
        rst_n = 1'b0;
        bus_cyc = 1'b0;
        bus_we = 1'b0;
        bus_adr = '0;
        bus_wdat = '0;
        sd_in = '0;
        for (int r = 0; r < ROWS; r++) begin
            for (int n = 0; n < LINES; n++) begin
                rx_left[r][n] = 16'($random(seed));
                rx_right[r][n] = 16'($random(seed));
            end
            tx_left[r] = 16'($random(seed));
            tx_right[r] = 16'($random(seed));
        end
        // Full scale row
        for (int n = 0; n < LINES; n++) begin
            rx_left[2][n] = 16'h8001;
            rx_right[2][n] = 16'h7fff;
        end
        tx_left[2] = 16'h8001;
        tx_right[2] = 16'h7fff;

        repeat (3) @(posedge ck);
        rst_n <= 1'b1;

        bus_read(reg_addr(0), data);
        check_value("frame register after reset", 0, data);
        bus_read(reg_addr(3), data);
        check_value("register 3 after reset", 0, data);

        for (int k = 0; k <= ROWS; k++) begin
            if (k > 0) begin
                // Let the eight capture writes finish
                wait_frames(k);
                repeat (`AUDIO_CHANNELS + 2) @(posedge ck);
                bus_read(reg_addr(0), data);
                check_value($sformatf("frame counter after start %0d", k),
                            (`AUDIO_FRAMES - k) % `AUDIO_FRAMES, data);
                frame = data[7:0];
                for (int c = 0; c < `AUDIO_CHANNELS; c++) begin
                    bus_read(audio_addr(c, frame), data);
                    sample = (c % 2 == 0) ? rx_left[k-1][c/2] : rx_right[k-1][c/2];
                    check_value($sformatf("capture row %0d channel %0d", k - 1, c),
                                sample, data);
                end
            end
            if (k < ROWS) begin
                bus_write(reg_addr(1), tx_left[k]);
                bus_write(reg_addr(2), tx_right[k]);
                bus_read(reg_addr(1), data);
                check_value($sformatf("left readback row %0d", k), tx_left[k], data);
                bus_read(reg_addr(2), data);
                check_value($sformatf("right readback row %0d", k), tx_right[k], data);
                // Other registers now hold nonzero values
                bus_read(reg_addr(3), data);
                check_value($sformatf("register 3 row %0d", k), 0, data);
            end
        end

        // Last row plays out in the frame after its capture check
        wait_frames(ROWS + 1);
        @(posedge ck);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/audio_pkg.sv
rtl/i2s_clock.sv
rtl/i2s_rx.sv
rtl/i2s_tx.sv
rtl/frame_capture.sv
rtl/audio_ram.sv
rtl/host_regs.sv
rtl/audio_capture_top.sv
test/tb_audio_capture.sv

// ==== Bender.yml ====
package:
  name: audio_capture

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/audio_pkg.sv
      - rtl/i2s_clock.sv
      - rtl/i2s_rx.sv
      - rtl/i2s_tx.sv
      - rtl/frame_capture.sv
      - rtl/audio_ram.sv
      - rtl/host_regs.sv
      - rtl/audio_capture_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_audio_capture.sv
